// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := wisc_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
PASS_MSG  := PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== decode_unit.sv ====
// Decode stage: field extraction, control decode, register file, scoreboard stall, ID/EX register
module decode_unit (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [wisc_isa_pkg::word_w-1:0] instr,
	input  logic [wisc_isa_pkg::word_w-1:0] pc_in,
	input  logic                            valid_in,
	input  logic                            flush,
	input  logic                            mem_busy,
	input  logic                            wb_en,
	input  logic [wisc_isa_pkg::reg_w-1:0]  wb_reg,
	input  logic [wisc_isa_pkg::word_w-1:0] wb_data,
	output logic                            stall,
	output wisc_isa_pkg::opcode_e           op,
	output wisc_isa_pkg::cond_e             cond,
	output logic [wisc_isa_pkg::reg_w-1:0]  rd,
	output logic [wisc_isa_pkg::word_w-1:0] src_a,
	output logic [wisc_isa_pkg::word_w-1:0] src_b,
	output logic [wisc_isa_pkg::imm_w-1:0]  imm,
	output logic [wisc_isa_pkg::word_w-1:0] pc_out,
	output logic                            valid_out
);
	import wisc_isa_pkg::*;

	opcode_e           opc;
	logic [reg_w-1:0]  rd_f;
	logic [reg_w-1:0]  ra_idx;
	logic [reg_w-1:0]  rb_idx;
	logic              legal;
	logic              use_a;
	logic              use_b;
	logic              writes;
	logic [word_w-1:0] rf [reg_cnt];
	logic [word_w-1:0] rd_a;
	logic [word_w-1:0] rd_b;
	logic [1:0]        sb_v;         // Entry 0 is ID/EX, entry 1 is EX/MEM
	logic [reg_w-1:0]  sb_reg [2];
	logic              hit_a;
	logic              hit_b;
	logic              issue;

	assign opc  = opcode_e'(instr[15:12]);
	assign rd_f = instr[11:8];

	always_comb begin
		legal  = 1'b1;
		use_a  = 1'b0;
		use_b  = 1'b0;
		writes = 1'b0;
		ra_idx = instr[7:4];
		rb_idx = instr[3:0];
		case (opc)
			ADD, SUB, NAND: begin
				use_a  = 1'b1;
				use_b  = 1'b1;
				writes = 1'b1;
			end
			SLL, SRL, LW: begin
				use_a  = 1'b1;  // Low nibble is shift or offset
				writes = 1'b1;
			end
			SW: begin
				use_a  = 1'b1;
				use_b  = 1'b1;
				rb_idx = rd_f;  // Store data register
			end
			LHB, LLB: begin
				use_a  = 1'b1;
				ra_idx = rd_f;  // Merge keeps the other byte of rd
				writes = 1'b1;
			end
			BR, HLT: ;
			default: legal = 1'b0;  // Unknown opcodes retire silently
		endcase
	end

	// Write-before-read through the bypass
	assign rd_a = (ra_idx == '0) ? '0 : (wb_en && wb_reg == ra_idx) ? wb_data : rf[ra_idx];
	assign rd_b = (rb_idx == '0) ? '0 : (wb_en && wb_reg == rb_idx) ? wb_data : rf[rb_idx];

	always_ff @(posedge clk) begin
		if (wb_en)
			rf[wb_reg] <= wb_data;
	end

	assign hit_a = (sb_v[0] && sb_reg[0] == ra_idx) || (sb_v[1] && sb_reg[1] == ra_idx);
	assign hit_b = (sb_v[0] && sb_reg[0] == rb_idx) || (sb_v[1] && sb_reg[1] == rb_idx);
	assign stall = valid_in & ((use_a & hit_a) | (use_b & hit_b));
	assign issue = valid_in & legal & ~stall & ~flush;

	always_ff @(posedge clk) begin
		if (rst) begin
			sb_v      <= '0;
			valid_out <= 1'b0;
		end else if (~mem_busy) begin
			sb_v[1]   <= sb_v[0];
			sb_v[0]   <= issue & writes & (rd_f != '0);
			valid_out <= issue;  // Bubble on stall or flush
		end
	end

	always_ff @(posedge clk) begin
		if (~mem_busy) begin
			sb_reg[1] <= sb_reg[0];
			sb_reg[0] <= rd_f;
			op        <= opc;
			cond      <= cond_e'(instr[8 +: cond_w]);
			rd        <= rd_f;
			src_a     <= rd_a;
			src_b     <= rd_b;
			imm       <= instr[imm_w-1:0];
			pc_out    <= pc_in;
		end
	end

endmodule

// ==== execute_unit.sv ====
// Execute stage: saturating ALU, halfword merges, Z/N/V flags, branch resolution, EX/MEM register
module execute_unit (
	input  logic                            clk,
	input  logic                            rst,
	input  wisc_isa_pkg::opcode_e           op,
	input  wisc_isa_pkg::cond_e             cond,
	input  logic [wisc_isa_pkg::reg_w-1:0]  rd,
	input  logic [wisc_isa_pkg::word_w-1:0] src_a,
	input  logic [wisc_isa_pkg::word_w-1:0] src_b,
	input  logic [wisc_isa_pkg::imm_w-1:0]  imm,
	input  logic [wisc_isa_pkg::word_w-1:0] pc,
	input  logic                            valid_in,
	input  logic                            mem_busy,
	output logic                            branch_taken,
	output logic [wisc_isa_pkg::word_w-1:0] branch_target,
	output logic [wisc_isa_pkg::word_w-1:0] result,
	output logic [wisc_isa_pkg::word_w-1:0] store_data,
	output logic [wisc_isa_pkg::reg_w-1:0]  dest,
	output logic                            reg_we,
	output logic                            mem_read,
	output logic                            mem_write,
	output logic                            is_halt,
	output logic                            valid_out
);
	import wisc_isa_pkg::*;

	logic [word_w-1:0]  off_ext;
	logic [word_w-1:0]  imm_ext;
	logic [shamt_w-1:0] shamt;
	logic [word_w-1:0]  sum;
	logic [word_w-1:0]  diff;
	logic [word_w-1:0]  sat_val;   // Clamp toward the sign of src_a
	logic               add_ovf;
	logic               sub_ovf;
	logic [word_w-1:0]  alu_y;
	logic               flag_z;
	logic               flag_n;
	logic               flag_v;
	logic               taken_cond;
	logic               fire;      // Instruction leaves EX this cycle

	assign shamt   = imm[shamt_w-1:0];
	assign off_ext = {{(word_w-shamt_w){imm[shamt_w-1]}}, shamt};
	assign imm_ext = {{(word_w-imm_w){imm[imm_w-1]}}, imm};
	assign sum     = src_a + src_b;
	assign diff    = src_a - src_b;
	assign sat_val = {src_a[word_w-1], {(word_w-1){~src_a[word_w-1]}}};
	assign add_ovf = (src_a[word_w-1] == src_b[word_w-1]) && (sum[word_w-1] != src_a[word_w-1]);
	assign sub_ovf = (src_a[word_w-1] != src_b[word_w-1]) && (diff[word_w-1] != src_a[word_w-1]);

	always_comb begin
		case (op)
			ADD:     alu_y = add_ovf ? sat_val : sum;
			SUB:     alu_y = sub_ovf ? sat_val : diff;
			NAND:    alu_y = ~(src_a & src_b);
			SLL:     alu_y = src_a << shamt;
			SRL:     alu_y = src_a >> shamt;
			LLB:     alu_y = {src_a[word_w-1:imm_w], imm};
			LHB:     alu_y = {imm, src_a[imm_w-1:0]};
			LW, SW:  alu_y = src_a + off_ext;  // Word address
			default: alu_y = '0;
		endcase
	end

	always_comb begin
		case (cond)
			NE:      taken_cond = ~flag_z;
			EQ:      taken_cond = flag_z;
			GT:      taken_cond = ~flag_z & ~flag_n;
			LT:      taken_cond = flag_n;
			GE:      taken_cond = ~flag_n;
			LE:      taken_cond = flag_n | flag_z;
			OV:      taken_cond = flag_v;
			default: taken_cond = 1'b1;  // UN
		endcase
	end

	assign fire          = valid_in & ~mem_busy;
	assign branch_taken  = fire & (op == BR) & taken_cond;
	assign branch_target = pc + 1'b1 + imm_ext;

	always_ff @(posedge clk) begin
		if (rst) begin
			flag_z <= 1'b0;
			flag_n <= 1'b0;
			flag_v <= 1'b0;
		end else if (fire && op inside {ADD, SUB, NAND, SLL, SRL}) begin
			flag_z <= (alu_y == '0);
			flag_n <= alu_y[word_w-1];
			if (op inside {ADD, SUB})
				flag_v <= (op == ADD) ? add_ovf : sub_ovf;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_out <= 1'b0;
			reg_we    <= 1'b0;
			mem_read  <= 1'b0;
			mem_write <= 1'b0;
			is_halt   <= 1'b0;
		end else if (~mem_busy) begin
			valid_out <= valid_in;
			reg_we    <= valid_in & (op inside {ADD, SUB, NAND, SLL, SRL, LW, LHB, LLB});
			mem_read  <= valid_in & (op == LW);
			mem_write <= valid_in & (op == SW);
			is_halt   <= valid_in & (op == HLT);
		end
	end

	always_ff @(posedge clk) begin
		if (~mem_busy) begin
			result     <= alu_y;
			store_data <= src_b;
			dest       <= rd;
		end
	end

endmodule

// ==== fetch_unit.sv ====
// Fetch stage: program counter, instruction request with retry, IF/ID register with flush and stall
module fetch_unit (
	input  logic                            clk,
	input  logic                            rst,
	mem_bus_if.requester                    bus,
	input  logic                            stall,
	input  logic                            mem_busy,
	input  logic                            branch_taken,
	input  logic [wisc_isa_pkg::word_w-1:0] branch_target,
	input  logic                            halt,
	output logic [wisc_isa_pkg::word_w-1:0] instr,
	output logic [wisc_isa_pkg::word_w-1:0] pc,
	output logic                            valid
);
	import wisc_isa_pkg::*;
	import wisc_mem_pkg::*;

	logic [word_w-1:0] fetch_pc_q;    // Next address to request
	logic              pend_q;        // Word from last cycle's grant is on rdata
	logic [word_w-1:0] pend_pc_q;
	logic              hold_q;        // Word parked while decode is held
	logic [word_w-1:0] hold_instr_q;
	logic [word_w-1:0] hold_pc_q;
	logic              advance;       // Decode takes the IF/ID word this cycle

	assign advance = ~stall & ~mem_busy;
	assign valid   = hold_q | pend_q;
	assign instr   = hold_q ? hold_instr_q : bus.rdata;
	assign pc      = hold_q ? hold_pc_q : pend_pc_q;

	// One request per cycle, only if the IF/ID slot is free next cycle
	assign bus.req   = ~halt & ~branch_taken & (~valid | advance);
	assign bus.we    = 1'b0;
	assign bus.addr  = fetch_pc_q[addr_w-1:0];
	assign bus.wdata = '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			fetch_pc_q <= '0;
			pend_q     <= 1'b0;
			pend_pc_q  <= '0;
			hold_q     <= 1'b0;
		end else begin
			pend_q    <= bus.req & bus.gnt;  // Denied request leaves a bubble
			pend_pc_q <= fetch_pc_q;
			if (branch_taken)
				fetch_pc_q <= branch_target;
			else if (bus.req & bus.gnt)
				fetch_pc_q <= fetch_pc_q + 1'b1;
			hold_q <= ~branch_taken & valid & ~advance;  // Flush drops the word
		end
	end

	always_ff @(posedge clk) begin
		if (valid & ~advance) begin
			hold_instr_q <= instr;
			hold_pc_q    <= pc;
		end
	end

endmodule

// ==== flist.f ====
wisc_isa_pkg.sv
wisc_mem_pkg.sv
mem_bus_if.sv
unified_mem.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
mem_wb_unit.sv
wisc_top.sv
wisc_props.sv
wisc_tb.sv

// ==== mem_bus_if.sv ====
// Memory request interface for one requester, with requester and memory modports
interface mem_bus_if;
	import wisc_isa_pkg::*;
	import wisc_mem_pkg::*;

	logic              req;    // Access wanted this cycle
	logic              we;
	logic [addr_w-1:0] addr;
	logic [word_w-1:0] wdata;
	logic              gnt;    // Same cycle as req
	logic [word_w-1:0] rdata;  // One cycle after a granted read

	modport requester (
		output req, we, addr, wdata,
		input  gnt, rdata
	);

	modport mem (
		input  req, we, addr, wdata,
		output gnt, rdata
	);

endinterface

// ==== mem_wb_unit.sv ====
// Memory and writeback stage: load and store requests, writeback select, register write and halt
module mem_wb_unit (
	input  logic                            clk,
	input  logic                            rst,
	input  logic [wisc_isa_pkg::word_w-1:0] result,
	input  logic [wisc_isa_pkg::word_w-1:0] store_data,
	input  logic [wisc_isa_pkg::reg_w-1:0]  dest,
	input  logic                            reg_we,
	input  logic                            mem_read,
	input  logic                            mem_write,
	input  logic                            is_halt,
	input  logic                            valid_in,
	mem_bus_if.requester                    bus,
	output logic                            mem_busy,
	output logic                            wb_en,
	output logic [wisc_isa_pkg::reg_w-1:0]  wb_reg,
	output logic [wisc_isa_pkg::word_w-1:0] wb_data,
	output logic                            halt
);
	import wisc_mem_pkg::*;

	logic ld_wait_q;  // LW granted, data arrives this cycle
	logic halt_q;
	logic live;       // Nothing retires once halted

	assign live = valid_in & ~halt_q;

	assign bus.req   = live & (mem_write | (mem_read & ~ld_wait_q));
	assign bus.we    = mem_write;
	assign bus.addr  = result[addr_w-1:0];
	assign bus.wdata = store_data;

	// LW holds EX/MEM for its request cycle
	assign mem_busy = live & ((mem_read & ~ld_wait_q) | (mem_write & ~bus.gnt));

	assign wb_en   = live & reg_we & (dest != '0) & (~mem_read | ld_wait_q);
	assign wb_reg  = dest;
	assign wb_data = mem_read ? bus.rdata : result;
	assign halt    = halt_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			ld_wait_q <= 1'b0;
			halt_q    <= 1'b0;
		end else begin
			ld_wait_q <= bus.req & bus.gnt & mem_read;
			if (live & is_halt)
				halt_q <= 1'b1;  // Sticky until reset
		end
	end

endmodule

// ==== unified_mem.sv ====
// Unified memory: fixed-priority arbiter, single-ported word array with registered read, load port
module unified_mem (
	input  logic                            clk,
	input  logic                            rst,
	mem_bus_if.mem                          fetch,
	mem_bus_if.mem                          data,
	input  logic                            load_we,
	input  logic [wisc_mem_pkg::addr_w-1:0] load_addr,
	input  logic [wisc_isa_pkg::word_w-1:0] load_data
);
	import wisc_isa_pkg::*;
	import wisc_mem_pkg::*;

	logic [word_w-1:0] mem_array [mem_depth];
	logic [word_w-1:0] rd_q;       // Shared read register
	grant_e            grant;
	logic              acc_we;
	logic [addr_w-1:0] acc_addr;
	logic [word_w-1:0] acc_wdata;

	always_comb begin
		grant     = GNT_NONE;
		acc_we    = 1'b0;
		acc_addr  = fetch.addr;
		acc_wdata = fetch.wdata;
		if (data.req) begin
			grant     = GNT_DATA;  // Loads and stores first
			acc_we    = data.we;
			acc_addr  = data.addr;
			acc_wdata = data.wdata;
		end else if (fetch.req) begin
			grant  = GNT_FETCH;
			acc_we = fetch.we;
		end
	end

	assign fetch.gnt   = (grant == GNT_FETCH);
	assign data.gnt    = (grant == GNT_DATA);
	assign fetch.rdata = rd_q;  // Only the requester granted last cycle takes it
	assign data.rdata  = rd_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			if (load_we)
				mem_array[load_addr] <= load_data;  // Program image
		end else if (acc_we) begin
			mem_array[acc_addr] <= acc_wdata;
		end
		rd_q <= mem_array[acc_addr];
	end

endmodule

// ==== wisc_isa_pkg.sv ====
// ISA definitions: data and register widths, instruction field widths, opcode and branch-condition enums
package wisc_isa_pkg;

	localparam int word_w  = 16;  // Datapath width
	localparam int reg_cnt = 16;  // Architectural registers, r0 reads zero
	localparam int reg_w   = 4;   // Register index width
	localparam int op_w    = 4;   // Opcode in bits 15:12
	localparam int cond_w  = 3;   // Branch condition, low bits of 11:8
	localparam int imm_w   = 8;   // LLB, LHB and BR immediate in 7:0
	localparam int shamt_w = 4;   // Shift amount or memory offset in 3:0

	typedef enum logic [op_w-1:0] {
		ADD  = 4'h0,  // Saturating
		SUB  = 4'h2,  // Saturating
		NAND = 4'h3,
		SLL  = 4'h5,
		SRL  = 4'h6,
		LW   = 4'h8,
		SW   = 4'h9,  // Stores the register named in 11:8
		LHB  = 4'ha,
		LLB  = 4'hb,
		BR   = 4'hc,
		HLT  = 4'hf
	} opcode_e;

	typedef enum logic [cond_w-1:0] {
		NE = 3'b000,
		EQ = 3'b001,
		GT = 3'b010,
		LT = 3'b011,
		GE = 3'b100,
		LE = 3'b101,
		OV = 3'b110,
		UN = 3'b111   // Unconditional
	} cond_e;

endpackage

// ==== wisc_mem_pkg.sv ====
// Memory-system definitions: unified memory depth, word address width and arbiter grant encoding
package wisc_mem_pkg;

	localparam int mem_depth = 256;                // Words, code and data together
	localparam int addr_w    = $clog2(mem_depth);  // Low byte of a 16-bit address

	// Data port has priority over fetch
	typedef enum logic [1:0] {
		GNT_NONE  = 2'd0,
		GNT_FETCH = 2'd1,
		GNT_DATA  = 2'd2
	} grant_e;

endpackage

// ==== wisc_props.sv ====
// Bound assertions: arbiter priority, grant only on request, sticky halt, valids clear after reset
module wisc_props (
	input logic clk,
	input logic rst,
	input logic fetch_req,
	input logic fetch_gnt,
	input logic data_req,
	input logic data_gnt,
	input logic if_valid,
	input logic id_valid,
	input logic ex_valid,
	input logic wb_valid,
	input logic halt
);
	timeunit 1ns;
	timeprecision 1ps;

	a_data_first: assert property (@(posedge clk) disable iff (rst)
		(fetch_req && data_req) |-> (data_gnt && !fetch_gnt))
		else $error("arbiter granted fetch while the data port was requesting");

	a_gnt_needs_req: assert property (@(posedge clk) disable iff (rst)
		!(fetch_gnt && !fetch_req) && !(data_gnt && !data_req))
		else $error("grant given without a request");

	a_halt_sticky: assert property (@(posedge clk) disable iff (rst) halt |=> halt)
		else $error("halt fell outside reset");

	// First cycle out of reset
	a_clear_after_rst: assert property (@(posedge clk)
		$fell(rst) |-> !(if_valid || id_valid || ex_valid || wb_valid || halt))
		else $error("pipeline valid or halt high right after reset");

endmodule

bind wisc_top wisc_props u_props (
	.clk(clk), .rst(rst),
	.fetch_req(bus_fetch.req), .fetch_gnt(bus_fetch.gnt),
	.data_req(bus_data.req), .data_gnt(bus_data.gnt),
	.if_valid(if_valid), .id_valid(id_valid), .ex_valid(ex_valid),
	.wb_valid(wb_valid), .halt(halt)
);

// ==== wisc_tb.sv ====
// Testbench: LFSR program generator, ISA reference model, writeback, halt and count checks
module wisc_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import wisc_isa_pkg::*;
	import wisc_mem_pkg::*;

	localparam int num_tests = 4;
	localparam int body_len  = 24;     // Random instructions after the prologue
	localparam int run_limit = 3000;   // Cycles allowed to reach halt
	localparam int quiet_cyc = 12;     // Cycles watched after halt

	logic              clk;
	logic              rst;
	logic              load_we;
	logic [addr_w-1:0] load_addr;
	logic [word_w-1:0] load_data;
	logic              wb_valid;
	logic [reg_w-1:0]  wb_reg;
	logic [word_w-1:0] wb_data;
	logic              halt;

	logic [31:0]             lfsr_q;
	logic [word_w-1:0]       image [mem_depth];  // Code, then fill pattern
	logic [reg_w+word_w-1:0] exp_q [$];          // {reg, data} in retire order
	logic [reg_w+word_w-1:0] exp_wb;
	int                      err_cnt;
	int                      check_cnt;
	int                      wb_cnt;
	logic                    mon_on;
	string                   test_name;

	wisc_top DUT (
		.clk(clk), .rst(rst), .load_we(load_we), .load_addr(load_addr), .load_data(load_data),
		.wb_valid(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .halt(halt)
	);

	always #50 clk = ~clk;

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_q = lfsr_next(lfsr_q);
			v = {v[14:0], lfsr_q[0]};  // One step per bit
		end
	endtask

	task automatic compare(input string what, input logic [15:0] expected,
			input logic [15:0] actual);
		check_cnt++;
		if (expected !== actual) begin
			err_cnt++;
			$display("error %s %s: expected %h, actual %h", test_name, what, expected, actual);
		end
	endtask

	function automatic logic cond_holds(input logic [2:0] cc, input logic z, input logic n,
			input logic v);
		case (cc)
			NE:      return !z;
			EQ:      return z;
			GT:      return !z && !n;
			LT:      return n;
			GE:      return !n;
			LE:      return n || z;
			OV:      return v;
			default: return 1'b1;
		endcase
	endfunction

	task automatic build_program(output int last);
		logic [15:0] kind;
		logic [15:0] d;
		logic [15:0] s;
		logic [15:0] t;
		logic [15:0] lit;
		logic [3:0]  rd;
		logic [3:0]  rs;
		logic [3:0]  rt;
		int          pc;
		int          off;
		pc = 0;
		for (int r = 1; r < 8; r++) begin
			take_bits(8, lit);
			image[addr_w'(pc)]   = {ADD, 4'(r), 8'h00};     // Clear the register
			image[addr_w'(pc+1)] = {LLB, 4'(r), lit[7:0]};
			pc += 2;
		end
		image[addr_w'(pc)]   = {ADD, 4'hf, 8'h00};
		image[addr_w'(pc+1)] = {LLB, 4'hf, 8'h80};  // r15 is the data base
		pc += 2;
		last = pc + body_len;
		while (pc < last) begin
			take_bits(4, kind);
			take_bits(3, d);
			take_bits(3, s);
			take_bits(3, t);
			take_bits(8, lit);
			rd  = {1'b0, d[2:0]};
			rs  = {1'b0, s[2:0]};
			rt  = {1'b0, t[2:0]};
			off = (int'(lit[2:0]) > last - pc - 1) ? last - pc - 1 : int'(lit[2:0]);
			case (kind[3:0])
				4'd0, 4'd1:   image[addr_w'(pc)] = {ADD, rd, rs, rt};
				4'd2:         image[addr_w'(pc)] = {SUB, rd, rs, rt};
				4'd3:         image[addr_w'(pc)] = {NAND, rd, rs, rt};
				4'd4:         image[addr_w'(pc)] = {SLL, rd, rs, lit[3:0]};
				4'd5:         image[addr_w'(pc)] = {SRL, rd, rs, lit[3:0]};
				4'd6, 4'd7:   image[addr_w'(pc)] = {LLB, rd, lit[7:0]};
				4'd8:         image[addr_w'(pc)] = {LHB, rd, lit[7:0]};
				4'd9, 4'd10:  image[addr_w'(pc)] = {LW, rd, 4'hf, lit[3:0]};
				4'd11, 4'd12: image[addr_w'(pc)] = {SW, rd, 4'hf, lit[3:0]};
				default:      image[addr_w'(pc)] = {BR, rd, 8'(off)};  // Never past HLT
			endcase
			pc++;
		end
		image[addr_w'(last)] = {HLT, 12'h000};
		for (int a = last + 1; a < mem_depth; a++)
			image[addr_w'(a)] = {8'(a) ^ 8'hc3, 8'(a)};
	endtask

	// Sequential ISA execution, one instruction at a time
	task automatic run_model(input int last);
		logic [word_w-1:0] rf [reg_cnt];
		logic [word_w-1:0] dm [mem_depth];
		logic [word_w-1:0] ir;
		logic [word_w-1:0] a;
		logic [word_w-1:0] b;
		logic [word_w-1:0] c;
		logic [word_w-1:0] y;
		logic [addr_w-1:0] ea;
		logic [reg_w-1:0]  rd;
		logic              z;
		logic              n;
		logic              v;
		logic              wr;
		logic              done;
		int                sum;
		int                pc;
		int                steps;
		exp_q.delete();
		foreach (rf[i])
			rf[i] = '0;
		foreach (dm[i])
			dm[i] = image[i];
		z     = 1'b0;
		n     = 1'b0;
		v     = 1'b0;
		done  = 1'b0;
		pc    = 0;
		steps = 0;
		while (!done && pc <= last && steps < 4 * mem_depth) begin
			ir = image[addr_w'(pc)];
			rd = ir[11:8];
			a  = (ir[7:4] == '0) ? '0 : rf[ir[7:4]];
			b  = (ir[3:0] == '0) ? '0 : rf[ir[3:0]];
			c  = (rd == '0) ? '0 : rf[rd];
			ea = addr_w'(a + {{12{ir[3]}}, ir[3:0]});
			y  = '0;
			wr = 1'b1;
			pc++;
			steps++;
			case (ir[15:12])
				ADD, SUB: begin
					if (ir[15:12] == ADD)
						sum = int'($signed(a)) + int'($signed(b));
					else
						sum = int'($signed(a)) - int'($signed(b));
					v = (sum > 32767) || (sum < -32768);
					y = (sum > 32767) ? 16'h7fff : (sum < -32768) ? 16'h8000 : sum[15:0];
				end
				NAND: y = ~(a & b);
				SLL:  y = a << ir[3:0];
				SRL:  y = a >> ir[3:0];
				LLB:  y = {c[15:8], ir[7:0]};
				LHB:  y = {ir[7:0], c[7:0]};
				LW:   y = dm[ea];
				SW: begin
					dm[ea] = c;
					wr     = 1'b0;
				end
				BR: begin
					wr = 1'b0;
					if (cond_holds(ir[10:8], z, n, v))
						pc += int'($signed(ir[7:0]));
				end
				default: begin  // HLT
					wr   = 1'b0;
					done = 1'b1;
				end
			endcase
			if (ir[15:12] inside {ADD, SUB, NAND, SLL, SRL}) begin
				z = (y == '0);
				n = y[15];
			end
			if (wr && rd != '0) begin
				rf[rd] = y;
				exp_q.push_back({rd, y});
			end
		end
	endtask

	task automatic load_and_reset();
		mon_on = 1'b0;
		@(posedge clk);
		#1;
		rst = 1'b1;
		for (int a = 0; a < mem_depth; a++) begin
			load_we   = 1'b1;
			load_addr = addr_w'(a);
			load_data = image[addr_w'(a)];
			@(posedge clk);
			#1;
		end
		load_we = 1'b0;
		repeat (2) @(posedge clk);  // Reset cycles after the image is in
		#1;
		rst    = 1'b0;
		mon_on = 1'b1;
	endtask

	task automatic wait_for_halt(output logic reached);
		int cyc;
		cyc     = 0;
		reached = 1'b0;
		while (!reached && cyc < run_limit) begin
			@(posedge clk);
			#1;
			reached = halt;
			cyc++;
		end
		if (!reached) begin
			err_cnt++;
			$display("%s: halt did not rise within %0d cycles", test_name, run_limit);
		end
	endtask

	task automatic watch_after_halt();
		for (int i = 0; i < quiet_cyc; i++) begin
			@(negedge clk);
			compare("halt level", 16'h0001, {15'h0, halt});
		end
	endtask

	// Writebacks are sampled mid-cycle
	always @(negedge clk) begin
		if (mon_on && wb_valid) begin
			wb_cnt++;
			if (halt) begin
				err_cnt++;
				$display("%s: writeback to r%0d after halt", test_name, wb_reg);
			end else if (exp_q.size() == 0) begin
				err_cnt++;
				$display("%s: extra writeback r%0d = %h beyond the model's list",
					test_name, wb_reg, wb_data);
			end else begin
				exp_wb = exp_q.pop_front();
				compare("wb register", {12'h0, exp_wb[19:16]}, {12'h0, wb_reg});
				compare("wb data", exp_wb[15:0], wb_data);
			end
		end
	end

	initial begin
		int   last;
		int   exp_cnt;
		int   errs_before;
		logic reached;
		clk       = 1'b0;
		rst       = 1'b1;
		load_we   = 1'b0;
		load_addr = '0;
		load_data = '0;
		lfsr_q    = 32'hdbfa_906e;
		err_cnt   = 0;
		check_cnt = 0;
		wb_cnt    = 0;
		mon_on    = 1'b0;
		test_name = "setup";
		for (int t = 0; t < num_tests; t++) begin
			test_name   = $sformatf("program_%0d", t);
			errs_before = err_cnt;
			build_program(last);
			run_model(last);
			exp_cnt = exp_q.size();
			wb_cnt  = 0;
			load_and_reset();
			wait_for_halt(reached);
			if (reached) begin
				watch_after_halt();
				compare("wb count", 16'(exp_cnt), 16'(wb_cnt));
			end
			$display("%s: %0d of %0d writebacks, %0d errors", test_name, wb_cnt, exp_cnt,
				err_cnt - errs_before);
		end
		$display("%0d tests, %0d checks, %0d errors", num_tests, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== wisc_top.sv ====
// Processor top level: fetch, decode, execute and memory/writeback stages around the unified memory
module wisc_top (
	input  logic                            clk,
	input  logic                            rst,
	input  logic                            load_we,
	input  logic [wisc_mem_pkg::addr_w-1:0] load_addr,
	input  logic [wisc_isa_pkg::word_w-1:0] load_data,
	output logic                            wb_valid,
	output logic [wisc_isa_pkg::reg_w-1:0]  wb_reg,
	output logic [wisc_isa_pkg::word_w-1:0] wb_data,
	output logic                            halt
);
	import wisc_isa_pkg::*;

	mem_bus_if bus_fetch ();
	mem_bus_if bus_data ();

	logic [word_w-1:0] if_instr;       // IF/ID
	logic [word_w-1:0] if_pc;
	logic              if_valid;
	logic              stall;
	opcode_e           id_op;          // ID/EX
	cond_e             id_cond;
	logic [reg_w-1:0]  id_rd;
	logic [word_w-1:0] id_src_a;
	logic [word_w-1:0] id_src_b;
	logic [imm_w-1:0]  id_imm;
	logic [word_w-1:0] id_pc;
	logic              id_valid;
	logic              branch_taken;
	logic [word_w-1:0] branch_target;
	logic [word_w-1:0] ex_result;      // EX/MEM
	logic [word_w-1:0] ex_store_data;
	logic [reg_w-1:0]  ex_dest;
	logic              ex_reg_we;
	logic              ex_mem_read;
	logic              ex_mem_write;
	logic              ex_is_halt;
	logic              ex_valid;
	logic              mem_busy;

	fetch_unit u_fetch (
		.clk(clk), .rst(rst), .bus(bus_fetch.requester), .stall(stall), .mem_busy(mem_busy),
		.branch_taken(branch_taken), .branch_target(branch_target), .halt(halt),
		.instr(if_instr), .pc(if_pc), .valid(if_valid)
	);

	decode_unit u_decode (
		.clk(clk), .rst(rst), .instr(if_instr), .pc_in(if_pc), .valid_in(if_valid),
		.flush(branch_taken), .mem_busy(mem_busy),
		.wb_en(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .stall(stall),
		.op(id_op), .cond(id_cond), .rd(id_rd), .src_a(id_src_a), .src_b(id_src_b),
		.imm(id_imm), .pc_out(id_pc), .valid_out(id_valid)
	);

	execute_unit u_execute (
		.clk(clk), .rst(rst), .op(id_op), .cond(id_cond), .rd(id_rd),
		.src_a(id_src_a), .src_b(id_src_b), .imm(id_imm), .pc(id_pc), .valid_in(id_valid),
		.mem_busy(mem_busy), .branch_taken(branch_taken), .branch_target(branch_target),
		.result(ex_result), .store_data(ex_store_data), .dest(ex_dest), .reg_we(ex_reg_we),
		.mem_read(ex_mem_read), .mem_write(ex_mem_write), .is_halt(ex_is_halt),
		.valid_out(ex_valid)
	);

	mem_wb_unit u_mem_wb (
		.clk(clk), .rst(rst), .result(ex_result), .store_data(ex_store_data),
		.dest(ex_dest), .reg_we(ex_reg_we), .mem_read(ex_mem_read),
		.mem_write(ex_mem_write), .is_halt(ex_is_halt), .valid_in(ex_valid),
		.bus(bus_data.requester), .mem_busy(mem_busy),
		.wb_en(wb_valid), .wb_reg(wb_reg), .wb_data(wb_data), .halt(halt)
	);

	unified_mem u_mem (
		.clk(clk), .rst(rst), .fetch(bus_fetch.mem), .data(bus_data.mem),
		.load_we(load_we), .load_addr(load_addr), .load_data(load_data)
	);

endmodule
